// File: trace_repo_config.svh
`ifndef TRACE_REPO_CONFIG_SVH
`define TRACE_REPO_CONFIG_SVH

// Width of the memory address carried in each trace word
`define TRACE_ADDR_W 16

// Width of the instruction carried in each trace word
`define TRACE_INSTR_W 32

// The trace memory holds 2**TRACE_DEPTH_LOG2 entries
`define TRACE_DEPTH_LOG2 4

// Width of each commit outcome counter
`define EVENT_COUNT_W 16

`endif

// File: trace_repo_pkg.sv
`default_nettype none

`include "trace_repo_config.svh"

package trace_repo_pkg;

    // Field view of a trace word, address in the upper bits
    typedef struct packed {
        bit [`TRACE_ADDR_W-1:0]  addr;
        bit [`TRACE_INSTR_W-1:0] instr;
    } trace_fields_t;

    // The memory handles a trace word as one raw word, the replay side decodes the fields
    typedef union packed {
        bit [`TRACE_ADDR_W+`TRACE_INSTR_W-1:0] raw;
        trace_fields_t                         fields;
    } trace_word_u;

    typedef bit [`TRACE_DEPTH_LOG2-1:0] trace_index_t;

    // One extra bit so that a completely full store can be counted
    typedef bit [`TRACE_DEPTH_LOG2:0] trace_count_t;

    typedef bit [`EVENT_COUNT_W-1:0] event_count_t;

endpackage

`default_nettype wire

// File: trace_capture.sv
`default_nettype none

`include "trace_repo_config.svh"

module trace_capture (
    input  wire                          clk,
    input  wire                          rst_n,
    input  bit                           lock_i,
    input  bit                           capture_en_i,
    input  bit                           trace_ready_i,
    input  trace_repo_pkg::trace_word_u  trace_word_i,
    output bit                           wr_en_o,
    output trace_repo_pkg::trace_index_t wr_index_o,
    output trace_repo_pkg::trace_word_u  wr_word_o,
    output trace_repo_pkg::trace_count_t captured_count_o
);

    import trace_repo_pkg::*;

    localparam int unsigned SLOTS = 1 << `TRACE_DEPTH_LOG2;

    // Number of strobes accepted so far, which runs one cycle ahead of the stored count
    trace_count_t accepted_q;
    bit           accept;

    assign accept = !lock_i && capture_en_i && trace_ready_i && (accepted_q != SLOTS);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            accepted_q       <= '0;
            wr_en_o          <= 1'b0;
            captured_count_o <= '0;
        end
        else
        begin
            wr_en_o <= accept;
            if (accept)
            begin
                accepted_q <= accepted_q + 1'b1;
            end
            // The entry only counts as captured once its write has reached the store
            if (wr_en_o)
            begin
                captured_count_o <= captured_count_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            wr_index_o <= accepted_q[`TRACE_DEPTH_LOG2-1:0];
            wr_word_o  <= trace_word_i;
        end
    end

    // Once lock has been high for a full cycle there is no write left in flight
    a_no_write_when_locked: assert property (
        @(posedge clk) disable iff (!rst_n)
        (lock_i && $past(lock_i)) |-> !wr_en_o
    );

endmodule

`default_nettype wire

// File: trace_store.sv
`default_nettype none

`include "trace_repo_config.svh"

module trace_store (
    input  wire                          clk,
    input  bit                           wr_en_i,
    input  trace_repo_pkg::trace_index_t wr_index_i,
    input  trace_repo_pkg::trace_word_u  wr_word_i,
    input  bit                           rd_en_i,
    input  trace_repo_pkg::trace_index_t rd_index_i,
    output trace_repo_pkg::trace_word_u  rd_word_o
);

    localparam int unsigned SLOTS  = 1 << `TRACE_DEPTH_LOG2;
    localparam int unsigned WORD_W = `TRACE_ADDR_W + `TRACE_INSTR_W;

    // The memory keeps only the raw view of each word
    bit [WORD_W-1:0] mem [SLOTS];

    always_ff @(posedge clk)
    begin
        if (wr_en_i)
        begin
            mem[wr_index_i] <= wr_word_i.raw;
        end
    end

    // Registered read port, data follows rd_en_i by one cycle
    always_ff @(posedge clk)
    begin
        if (rd_en_i)
        begin
            rd_word_o.raw <= mem[rd_index_i];
        end
    end

    // Replay only reads slots that capture has already finished writing
    a_no_rw_collision: assert property (
        @(posedge clk)
        !(wr_en_i && rd_en_i && (wr_index_i == rd_index_i))
    );

endmodule

`default_nettype wire

// File: trace_replay.sv
`default_nettype none

`include "trace_repo_config.svh"

module trace_replay (
    input  wire                          clk,
    input  wire                          rst_n,
    input  bit                           lock_i,
    input  bit                           trace_req_i,
    input  bit                           mark_done_i,
    input  bit                           hit_i,
    input  bit                           store_i,
    input  trace_repo_pkg::trace_count_t captured_count_i,
    output bit                           rd_en_o,
    output trace_repo_pkg::trace_index_t rd_index_o,
    input  trace_repo_pkg::trace_word_u  rd_word_i,
    output bit [`TRACE_ADDR_W-1:0]       trace_addr_o,
    output bit [`TRACE_INSTR_W-1:0]      trace_instr_o,
    output trace_repo_pkg::trace_index_t trace_index_o,
    output bit                           entry_valid_o,
    output bit                           mark_done_valid_o,
    output bit                           processing_complete_o,
    output trace_repo_pkg::event_count_t hit_load_count_o,
    output trace_repo_pkg::event_count_t hit_store_count_o,
    output trace_repo_pkg::event_count_t miss_load_count_o,
    output trace_repo_pkg::event_count_t miss_store_count_o
);

    import trace_repo_pkg::*;

    typedef enum bit [1:0] {
        ST_LISTEN,
        ST_FETCH,
        ST_READY
    } replay_state_e;

    replay_state_e state_q;

    // Entries read out of the store, handed out, and committed
    trace_count_t prefetch_count_q;
    trace_count_t replay_count_q;
    trace_count_t commit_count_q;

    // High in the cycle the store presents the requested word
    bit          rd_done_q;
    trace_word_u entry_q;
    bit          hand_out;
    bit          commit_ok;

    assign rd_index_o = prefetch_count_q[`TRACE_DEPTH_LOG2-1:0];
    assign hand_out   = (state_q == ST_READY) && lock_i && trace_req_i;

    // Only entries already handed out may be committed, one pulse at a time
    assign commit_ok = lock_i && mark_done_i && !mark_done_valid_o &&
                       (commit_count_q < replay_count_q);

    assign processing_complete_o = lock_i && (captured_count_i != '0) &&
                                   (commit_count_q == captured_count_i);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q          <= ST_LISTEN;
            prefetch_count_q <= '0;
            replay_count_q   <= '0;
            rd_en_o          <= 1'b0;
            rd_done_q        <= 1'b0;
            entry_valid_o    <= 1'b0;
        end
        else
        begin
            rd_en_o       <= 1'b0;
            rd_done_q     <= rd_en_o;
            entry_valid_o <= 1'b0;
            unique case (state_q)
                ST_LISTEN:
                begin
                    // Prefetch the next entry as soon as one is stored and unreplayed
                    if (lock_i && (prefetch_count_q < captured_count_i))
                    begin
                        rd_en_o <= 1'b1;
                        state_q <= ST_FETCH;
                    end
                end
                ST_FETCH:
                begin
                    if (rd_done_q)
                    begin
                        prefetch_count_q <= prefetch_count_q + 1'b1;
                        state_q          <= ST_READY;
                    end
                end
                ST_READY:
                begin
                    if (hand_out)
                    begin
                        entry_valid_o  <= 1'b1;
                        replay_count_q <= replay_count_q + 1'b1;
                        state_q        <= ST_LISTEN;
                    end
                end
                default:
                begin
                    state_q <= ST_LISTEN;
                end
            endcase
        end
    end

    // Prefetched word and the held output fields
    always_ff @(posedge clk)
    begin
        if ((state_q == ST_FETCH) && rd_done_q)
        begin
            entry_q <= rd_word_i;
        end
        if (hand_out)
        begin
            trace_addr_o  <= entry_q.fields.addr;
            trace_instr_o <= entry_q.fields.instr;
            trace_index_o <= replay_count_q[`TRACE_DEPTH_LOG2-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            commit_count_q     <= '0;
            mark_done_valid_o  <= 1'b0;
            hit_load_count_o   <= '0;
            hit_store_count_o  <= '0;
            miss_load_count_o  <= '0;
            miss_store_count_o <= '0;
        end
        else
        begin
            mark_done_valid_o <= commit_ok;
            if (commit_ok)
            begin
                commit_count_q <= commit_count_q + 1'b1;
                // Exactly one outcome class per committed entry
                unique case ({hit_i, store_i})
                    2'b10:   hit_load_count_o   <= hit_load_count_o + 1'b1;
                    2'b11:   hit_store_count_o  <= hit_store_count_o + 1'b1;
                    2'b00:   miss_load_count_o  <= miss_load_count_o + 1'b1;
                    default: miss_store_count_o <= miss_store_count_o + 1'b1;
                endcase
            end
        end
    end

    // Once everything captured has been replayed no further entry is handed out
    a_no_entry_after_end: assert property (
        @(posedge clk) disable iff (!rst_n)
        (replay_count_q == captured_count_i) |=> !entry_valid_o
    );

    a_commit_le_replay: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_count_q <= replay_count_q
    );

endmodule

`default_nettype wire

// File: trace_repository.sv
`default_nettype none

`include "trace_repo_config.svh"

module trace_repository (
    input  wire                          clk,
    input  wire                          rst_n,
    input  bit                           lock_i,
    input  bit                           capture_en_i,
    input  bit                           trace_ready_i,
    input  bit [`TRACE_ADDR_W-1:0]       trace_addr_i,
    input  bit [`TRACE_INSTR_W-1:0]      trace_instr_i,
    input  bit                           trace_req_i,
    input  bit                           mark_done_i,
    input  bit                           hit_i,
    input  bit                           store_i,
    output bit [`TRACE_ADDR_W-1:0]       trace_addr_o,
    output bit [`TRACE_INSTR_W-1:0]      trace_instr_o,
    output trace_repo_pkg::trace_index_t trace_index_o,
    output bit                           entry_valid_o,
    output bit                           mark_done_valid_o,
    output bit                           processing_complete_o,
    output trace_repo_pkg::event_count_t hit_load_count_o,
    output trace_repo_pkg::event_count_t hit_store_count_o,
    output trace_repo_pkg::event_count_t miss_load_count_o,
    output trace_repo_pkg::event_count_t miss_store_count_o
);

    import trace_repo_pkg::*;

    trace_word_u  trace_word;
    bit           wr_en;
    trace_index_t wr_index;
    trace_word_u  wr_word;
    trace_count_t captured_count;
    bit           rd_en;
    trace_index_t rd_index;
    trace_word_u  rd_word;

    // Incoming address and instruction are combined through the field view
    assign trace_word.fields = '{addr: trace_addr_i, instr: trace_instr_i};

    trace_capture u_capture (
        .clk              (clk),
        .rst_n            (rst_n),
        .lock_i           (lock_i),
        .capture_en_i     (capture_en_i),
        .trace_ready_i    (trace_ready_i),
        .trace_word_i     (trace_word),
        .wr_en_o          (wr_en),
        .wr_index_o       (wr_index),
        .wr_word_o        (wr_word),
        .captured_count_o (captured_count)
    );

    trace_store u_store (
        .clk        (clk),
        .wr_en_i    (wr_en),
        .wr_index_i (wr_index),
        .wr_word_i  (wr_word),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .rd_word_o  (rd_word)
    );

    trace_replay u_replay (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .lock_i                (lock_i),
        .trace_req_i           (trace_req_i),
        .mark_done_i           (mark_done_i),
        .hit_i                 (hit_i),
        .store_i               (store_i),
        .captured_count_i      (captured_count),
        .rd_en_o               (rd_en),
        .rd_index_o            (rd_index),
        .rd_word_i             (rd_word),
        .trace_addr_o          (trace_addr_o),
        .trace_instr_o         (trace_instr_o),
        .trace_index_o         (trace_index_o),
        .entry_valid_o         (entry_valid_o),
        .mark_done_valid_o     (mark_done_valid_o),
        .processing_complete_o (processing_complete_o),
        .hit_load_count_o      (hit_load_count_o),
        .hit_store_count_o     (hit_store_count_o),
        .miss_load_count_o     (miss_load_count_o),
        .miss_store_count_o    (miss_store_count_o)
    );

endmodule

`default_nettype wire

// File: tb_trace_repository.sv
`default_nettype none

`include "trace_repo_config.svh"

module tb_trace_repository;

    import trace_repo_pkg::*;

    localparam int SLOTS      = 1 << `TRACE_DEPTH_LOG2;
    localparam int WORD_W     = `TRACE_ADDR_W + `TRACE_INSTR_W;
    localparam int WAIT_LIMIT = 20;

    logic                      clk;
    logic                      rst_n;
    logic                      lock;
    logic                      capture_en;
    logic                      trace_ready;
    logic [`TRACE_ADDR_W-1:0]  trace_addr;
    logic [`TRACE_INSTR_W-1:0] trace_instr;
    logic                      trace_req;
    logic                      mark_done;
    logic                      hit;
    logic                      store;
    logic [`TRACE_ADDR_W-1:0]  out_addr;
    logic [`TRACE_INSTR_W-1:0] out_instr;
    trace_index_t              out_index;
    logic                      entry_valid;
    logic                      mark_done_valid;
    logic                      processing_complete;
    event_count_t              hit_load_count;
    event_count_t              hit_store_count;
    event_count_t              miss_load_count;
    event_count_t              miss_store_count;

    // Accepted trace words in capture order and the committed {hit, store} pairs
    logic [WORD_W-1:0] accepted_q [$];
    logic [1:0]        outcome_q [$];

    int          check_errors;
    int          timeouts;
    int          entries_seen;
    int          commits_seen;
    logic [15:0] lfsr_state;

    trace_repository uut (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .lock_i                (lock),
        .capture_en_i          (capture_en),
        .trace_ready_i         (trace_ready),
        .trace_addr_i          (trace_addr),
        .trace_instr_i         (trace_instr),
        .trace_req_i           (trace_req),
        .mark_done_i           (mark_done),
        .hit_i                 (hit),
        .store_i               (store),
        .trace_addr_o          (out_addr),
        .trace_instr_o         (out_instr),
        .trace_index_o         (out_index),
        .entry_valid_o         (entry_valid),
        .mark_done_valid_o     (mark_done_valid),
        .processing_complete_o (processing_complete),
        .hit_load_count_o      (hit_load_count),
        .hit_store_count_o     (hit_store_count),
        .miss_load_count_o     (miss_load_count),
        .miss_store_count_o    (miss_store_count)
    );

    always #20 clk = ~clk;

    // Expected outcome counter for one {hit, store} class
    function automatic int expected_tally(input logic [1:0] kind);
        int total;
        total = 0;
        foreach (outcome_q[i])
        begin
            if (outcome_q[i] == kind)
            begin
                total++;
            end
        end
        return total;
    endfunction

    // Expected contents of the replayed entry at a given position
    function automatic logic [WORD_W-1:0] expected_entry(input int index);
        return accepted_q[index];
    endfunction

    // Galois LFSR that steps once for each bit taken
    function automatic logic [63:0] draw_bits(input int count);
        logic [63:0] value;
        logic        lsb;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb)
            begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            value = {value[62:0], lsb};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Samples at the falling edge where the DUT outputs have settled
    task automatic wait_pulse(input bit commit_side, input string what, input bit expect_pulse,
                              output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            seen = commit_side ? mark_done_valid : entry_valid;
            cycles++;
        end
        if (expect_pulse && !seen)
        begin
            $display("Timeout: no %s pulse within %0d cycles", what, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    // Drives one capture strobe and mirrors it in the reference when the capture rules accept it
    task automatic capture_strobe(input logic ready);
        logic [63:0] word;
        word = draw_bits(WORD_W);
        next_cycle();
        capture_en                = 1'b1;
        trace_ready               = ready;
        {trace_addr, trace_instr} = word[WORD_W-1:0];
        if (!lock && ready && accepted_q.size() < SLOTS)
        begin
            accepted_q.push_back(word[WORD_W-1:0]);
        end
        next_cycle();
        capture_en  = 1'b0;
        trace_ready = 1'b0;
    endtask

    task automatic request_entry(input bit expect_entry);
        bit seen;
        next_cycle();
        trace_req = 1'b1;
        wait_pulse(1'b0, "entry_valid_o", expect_entry, seen);
        if (!expect_entry)
        begin
            check_value("request after end of replay", 0, seen);
        end
        next_cycle();
        trace_req = 1'b0;
    endtask

    task automatic commit_entry(input bit expect_commit);
        logic [63:0] bits;
        bit          seen;
        bits = draw_bits(2);
        next_cycle();
        mark_done = 1'b1;
        hit       = bits[1];
        store     = bits[0];
        if (expect_commit)
        begin
            outcome_q.push_back(bits[1:0]);
        end
        next_cycle();
        mark_done = 1'b0;
        wait_pulse(1'b1, "mark_done_valid_o", expect_commit, seen);
        if (!expect_commit)
        begin
            check_value("ignored commit pulse", 0, seen);
        end
    endtask

    // Compares every handed-out entry with the reference in capture order
    always @(negedge clk)
    begin
        logic [WORD_W-1:0] entry;
        if (rst_n && entry_valid)
        begin
            if (entries_seen < accepted_q.size())
            begin
                entry = expected_entry(entries_seen);
                check_value("replay address", entry[WORD_W-1 -: `TRACE_ADDR_W], out_addr);
                check_value("replay instruction", entry[`TRACE_INSTR_W-1:0], out_instr);
                check_value("replay index", entries_seen, out_index);
            end
            else
            begin
                $display("Entry handed out beyond the %0d captured words", accepted_q.size());
                check_errors++;
            end
            entries_seen++;
        end
        if (rst_n && mark_done_valid)
        begin
            commits_seen++;
        end
    end

    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        lock         = 1'b0;
        capture_en   = 1'b0;
        trace_ready  = 1'b0;
        trace_addr   = '0;
        trace_instr  = '0;
        trace_req    = 1'b0;
        mark_done    = 1'b0;
        hit          = 1'b0;
        store        = 1'b0;
        check_errors = 0;
        timeouts     = 0;
        entries_seen = 0;
        commits_seen = 0;
        lfsr_state   = 16'd64;

        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset entry_valid_o", 0, entry_valid);
        check_value("reset mark_done_valid_o", 0, mark_done_valid);
        check_value("reset processing_complete_o", 0, processing_complete);
        check_value("reset hit_load", 0, hit_load_count);
        check_value("reset hit_store", 0, hit_store_count);
        check_value("reset miss_load", 0, miss_load_count);
        check_value("reset miss_store", 0, miss_store_count);

        // Every third strobe comes without trace_ready and must not be stored
        for (int i = 0; i < 12; i++)
        begin
            capture_strobe(i % 3 != 2);
        end
        while (accepted_q.size() < SLOTS)
        begin
            capture_strobe(1'b1);
        end
        // The store is full, so these are dropped
        repeat (3) capture_strobe(1'b1);
        repeat (2) next_cycle();
        lock = 1'b1;
        repeat (3) capture_strobe(1'b1);

        // Nothing replayed yet, so a commit has nothing to act on
        commit_entry(1'b0);
        check_value("counters after ignored commit",
                    0, hit_load_count + hit_store_count + miss_load_count + miss_store_count);
        check_value("complete before replay", 0, processing_complete);

        for (int i = 0; i < SLOTS; i++)
        begin
            request_entry(1'b1);
            check_value("complete before commit", 0, processing_complete);
            commit_entry(1'b1);
            check_value("processing_complete_o after commit",
                        i == SLOTS - 1, processing_complete);
        end

        request_entry(1'b0);
        commit_entry(1'b0);
        repeat (3) next_cycle();

        check_value("entries replayed", SLOTS, entries_seen);
        check_value("commit pulses", SLOTS, commits_seen);
        check_value("hit_load count", expected_tally(2'b10), hit_load_count);
        check_value("hit_store count", expected_tally(2'b11), hit_store_count);
        check_value("miss_load count", expected_tally(2'b00), miss_load_count);
        check_value("miss_store count", expected_tally(2'b01), miss_store_count);
        check_value("processing_complete_o at end", 1, processing_complete);

        $display("Check failures: %0d, timeouts: %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
trace_repo_pkg.sv
trace_capture.sv
trace_store.sv
trace_replay.sv
trace_repository.sv
tb_trace_repository.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_trace_repository
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS := trace_repo_config.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
